// ==== design/muldiv_pkg.sv ====
package muldiv_pkg;

    localparam int XLEN        = 32;  // operand and register width
    localparam int MULT_STAGES = 7;   // multiplier stages after operand capture
    localparam int DIV_STEPS   = 32;  // one quotient bit per iteration
    localparam int DIV_CNT_W   = $clog2(DIV_STEPS);

    // operation codes offered by the issue stage
    typedef enum logic [3:0] {
        OP_MULT  = 4'd0,
        OP_MULTU = 4'd1,
        OP_DIV   = 4'd2,
        OP_DIVU  = 4'd3,
        OP_MADD  = 4'd4,
        OP_MADDU = 4'd5,
        OP_MSUB  = 4'd6,
        OP_MSUBU = 4'd7,
        OP_MTHI  = 4'd8,
        OP_MTLO  = 4'd9
    } op_e;

    // how a unit result lands in {hi, lo}
    typedef enum logic [1:0] {
        WR_LOAD = 2'd0,  // plain load
        WR_ADD  = 2'd1,  // accumulate
        WR_SUB  = 2'd2   // subtract from hi:lo
    } hilo_wr_e;

endpackage

// ==== design/muldiv_unit_if.sv ====
`timescale 1ns/1ps

interface muldiv_unit_if;

    logic                            start;      // one-cycle request
    logic [muldiv_pkg::XLEN-1:0]     a;
    logic [muldiv_pkg::XLEN-1:0]     b;
    logic                            is_signed;
    logic                            done;       // one-cycle completion
    logic [2*muldiv_pkg::XLEN-1:0]   result;     // {rem, quo} from the divider

    // sequencer side
    modport ctrl (
        output start,
        output a,
        output b,
        output is_signed,
        input  done,
        input  result
    );

    // arithmetic unit side
    modport unit (
        input  start,
        input  a,
        input  b,
        input  is_signed,
        output done,
        output result
    );

endinterface

// ==== design/hilo_regs.sv ====
`timescale 1ns/1ps

module hilo_regs (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            wr_en_i,
    input  muldiv_pkg::hilo_wr_e            wr_mode_i,
    input  logic [2*muldiv_pkg::XLEN-1:0]   wr_val_i,
    input  logic                            mov_hi_i,
    input  logic                            mov_lo_i,
    input  logic [muldiv_pkg::XLEN-1:0]     mov_val_i,
    output logic [muldiv_pkg::XLEN-1:0]     hi_o,
    output logic [muldiv_pkg::XLEN-1:0]     lo_o
);

    logic [muldiv_pkg::XLEN-1:0]   hi_q;
    logic [muldiv_pkg::XLEN-1:0]   lo_q;
    logic [2*muldiv_pkg::XLEN-1:0] hilo;      // current concatenation
    logic [2*muldiv_pkg::XLEN-1:0] hilo_nxt;  // value for a unit write

    assign hilo = {hi_q, lo_q};

    always_comb begin
        case (wr_mode_i)
            muldiv_pkg::WR_ADD:  hilo_nxt = hilo + wr_val_i;  // wraps mod 2^64
            muldiv_pkg::WR_SUB:  hilo_nxt = hilo - wr_val_i;
            default:             hilo_nxt = wr_val_i;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (mov_hi_i) begin
            hi_q <= mov_val_i;  // mthi
        end else if (mov_lo_i) begin
            lo_q <= mov_val_i;  // mtlo
        end else if (wr_en_i) begin
            {hi_q, lo_q} <= hilo_nxt;
        end
    end

    assign hi_o = hi_q;
    assign lo_o = lo_q;

endmodule

// ==== design/pipe_multiplier.sv ====
`timescale 1ns/1ps

module pipe_multiplier (
    input  logic           clk,
    input  logic           reset,
    muldiv_unit_if.unit    bus
);

    // operands carry one extra bit so signed and unsigned share the datapath
    logic signed [muldiv_pkg::XLEN:0]     a_q;
    logic signed [muldiv_pkg::XLEN:0]     b_q;
    logic [muldiv_pkg::MULT_STAGES:0]     vld_q;      // bit 0 is operand capture

    logic [muldiv_pkg::XLEN-1:0]          pp_ll_q;    // lo x lo, unsigned
    logic signed [muldiv_pkg::XLEN+1:0]   pp_lh_q;
    logic signed [muldiv_pkg::XLEN+1:0]   pp_hl_q;
    logic signed [muldiv_pkg::XLEN+1:0]   pp_hh_q;

    logic signed [muldiv_pkg::XLEN+2:0]   mid_q;      // cross terms summed
    logic [muldiv_pkg::XLEN-1:0]          ll_d_q;
    logic [muldiv_pkg::XLEN-1:0]          hh_d_q;     // upper bits fall off mod 2^64

    logic signed [2*muldiv_pkg::XLEN-1:0] mid_wide;
    logic [2*muldiv_pkg::XLEN-1:0]        mid_shift;
    logic [2*muldiv_pkg::XLEN-1:0]        prod_q [3:muldiv_pkg::MULT_STAGES];

    always_ff @(posedge clk) begin
        if (reset) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[muldiv_pkg::MULT_STAGES-1:0], bus.start};
        end
    end

    always_ff @(posedge clk) begin
        if (bus.start) begin
            a_q <= {bus.is_signed & bus.a[muldiv_pkg::XLEN-1], bus.a};
            b_q <= {bus.is_signed & bus.b[muldiv_pkg::XLEN-1], bus.b};
        end
    end

    // stage 1 forms four partial products on 16-bit halves
    always_ff @(posedge clk) begin
        pp_ll_q <= a_q[muldiv_pkg::XLEN/2-1:0] * b_q[muldiv_pkg::XLEN/2-1:0];
        pp_lh_q <= $signed({1'b0, a_q[muldiv_pkg::XLEN/2-1:0]})
                 * $signed(b_q[muldiv_pkg::XLEN:muldiv_pkg::XLEN/2]);
        pp_hl_q <= $signed(a_q[muldiv_pkg::XLEN:muldiv_pkg::XLEN/2])
                 * $signed({1'b0, b_q[muldiv_pkg::XLEN/2-1:0]});
        pp_hh_q <= $signed(a_q[muldiv_pkg::XLEN:muldiv_pkg::XLEN/2])
                 * $signed(b_q[muldiv_pkg::XLEN:muldiv_pkg::XLEN/2]);
    end

    // stage 2 folds the cross terms
    always_ff @(posedge clk) begin
        mid_q  <= pp_lh_q + pp_hl_q;
        ll_d_q <= pp_ll_q;
        hh_d_q <= pp_hh_q[muldiv_pkg::XLEN-1:0];
    end

    always_comb begin
        mid_wide  = mid_q;  // sign extends
        mid_shift = mid_wide <<< (muldiv_pkg::XLEN/2);
    end

    // stage 3 forms the product, later stages only carry it
    always_ff @(posedge clk) begin
        prod_q[3] <= {hh_d_q, {muldiv_pkg::XLEN{1'b0}}} + mid_shift
                   + {{muldiv_pkg::XLEN{1'b0}}, ll_d_q};
        for (int k = 4; k <= muldiv_pkg::MULT_STAGES; k++) begin
            prod_q[k] <= prod_q[k-1];
        end
    end

    assign bus.result = prod_q[muldiv_pkg::MULT_STAGES];
    assign bus.done   = vld_q[muldiv_pkg::MULT_STAGES];

endmodule

// ==== design/radix2_divider.sv ====
`timescale 1ns/1ps

module radix2_divider (
    input  logic           clk,
    input  logic           reset,
    muldiv_unit_if.unit    bus
);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_FIX
    } div_state_e;

    div_state_e                          state_q;
    logic [muldiv_pkg::DIV_CNT_W-1:0]    step_q;
    logic                                done_q;

    logic [muldiv_pkg::XLEN-1:0]         rem_q;      // partial remainder
    logic [muldiv_pkg::XLEN-1:0]         quo_q;      // dividend shifts out, quotient in
    logic [muldiv_pkg::XLEN-1:0]         dvs_q;      // divisor magnitude
    logic [muldiv_pkg::XLEN-1:0]         dvd_q;      // raw dividend for div by zero
    logic                                neg_quo_q;
    logic                                neg_rem_q;
    logic                                zero_q;
    logic [2*muldiv_pkg::XLEN-1:0]       result_q;

    logic [muldiv_pkg::XLEN-1:0]         a_mag;
    logic [muldiv_pkg::XLEN-1:0]         b_mag;
    logic [muldiv_pkg::XLEN:0]           shifted;
    logic [muldiv_pkg::XLEN+1:0]         diff;
    logic [muldiv_pkg::XLEN-1:0]         quo_fix;
    logic [muldiv_pkg::XLEN-1:0]         rem_fix;

    always_comb begin
        a_mag   = (bus.is_signed && bus.a[muldiv_pkg::XLEN-1]) ? -bus.a : bus.a;
        b_mag   = (bus.is_signed && bus.b[muldiv_pkg::XLEN-1]) ? -bus.b : bus.b;
        shifted = {rem_q, quo_q[muldiv_pkg::XLEN-1]};
        diff    = {1'b0, shifted} - {2'b00, dvs_q};  // msb set means borrow
        quo_fix = neg_quo_q ? -quo_q : quo_q;
        rem_fix = neg_rem_q ? -rem_q : rem_q;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= DIV_IDLE;
            step_q  <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                DIV_IDLE: begin
                    if (bus.start) begin
                        state_q <= DIV_RUN;
                        step_q  <= '0;
                    end
                end
                DIV_RUN: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == muldiv_pkg::DIV_STEPS - 1) begin
                        state_q <= DIV_FIX;
                    end
                end
                DIV_FIX: begin
                    state_q <= DIV_IDLE;
                    done_q  <= 1'b1;  // result_q loads on this same edge
                end
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == DIV_IDLE && bus.start) begin
            rem_q     <= '0;
            quo_q     <= a_mag;
            dvs_q     <= b_mag;
            dvd_q     <= bus.a;
            neg_quo_q <= bus.is_signed && (bus.a[muldiv_pkg::XLEN-1] ^ bus.b[muldiv_pkg::XLEN-1]);
            neg_rem_q <= bus.is_signed && bus.a[muldiv_pkg::XLEN-1];  // follows dividend
            zero_q    <= (bus.b == '0);
        end else if (state_q == DIV_RUN) begin
            if (!diff[muldiv_pkg::XLEN+1]) begin
                rem_q <= diff[muldiv_pkg::XLEN-1:0];  // subtract fits
                quo_q <= {quo_q[muldiv_pkg::XLEN-2:0], 1'b1};
            end else begin
                rem_q <= shifted[muldiv_pkg::XLEN-1:0];  // restore
                quo_q <= {quo_q[muldiv_pkg::XLEN-2:0], 1'b0};
            end
        end else if (state_q == DIV_FIX) begin
            if (zero_q) begin
                result_q <= {dvd_q, {muldiv_pkg::XLEN{1'b1}}};  // hi = dividend, lo = all ones
            end else begin
                result_q <= {rem_fix, quo_fix};
            end
        end
    end

    assign bus.done   = done_q;
    assign bus.result = result_q;

endmodule

// ==== design/muldiv_sequencer.sv ====
`timescale 1ns/1ps

module muldiv_sequencer (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            op_valid_i,
    output logic                            op_ready_o,
    input  muldiv_pkg::op_e                 op_code_i,
    input  logic [muldiv_pkg::XLEN-1:0]     a_i,
    input  logic [muldiv_pkg::XLEN-1:0]     b_i,
    input  logic                            flush_i,
    muldiv_unit_if.ctrl                     mul_bus,
    muldiv_unit_if.ctrl                     div_bus,
    output logic                            wr_en_o,
    output muldiv_pkg::hilo_wr_e            wr_mode_o,
    output logic [2*muldiv_pkg::XLEN-1:0]   wr_val_o,
    output logic                            mov_hi_o,
    output logic                            mov_lo_o,
    output logic [muldiv_pkg::XLEN-1:0]     mov_val_o
);

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_WAIT_MUL,
        SEQ_WAIT_DIV
    } seq_state_e;

    seq_state_e                  state_q;
    logic                        xfer;
    logic                        dec_mul;
    logic                        dec_div;
    logic                        dec_signed;
    logic                        dec_mthi;
    logic                        dec_mtlo;
    muldiv_pkg::hilo_wr_e        dec_mode;
    muldiv_pkg::hilo_wr_e        mode_q;
    logic [muldiv_pkg::XLEN-1:0] opa_q;  // also the move value
    logic [muldiv_pkg::XLEN-1:0] opb_q;
    logic                        sgn_q;
    logic                        mul_start_q;
    logic                        div_start_q;
    logic                        mov_hi_q;
    logic                        mov_lo_q;

    assign op_ready_o = (state_q == SEQ_IDLE);
    assign xfer       = op_valid_i && op_ready_o && !flush_i;

    always_comb begin
        dec_mul    = 1'b0;
        dec_div    = 1'b0;
        dec_signed = 1'b0;
        dec_mthi   = 1'b0;
        dec_mtlo   = 1'b0;
        dec_mode   = muldiv_pkg::WR_LOAD;
        case (op_code_i)
            muldiv_pkg::OP_MULT: begin
                dec_mul    = 1'b1;
                dec_signed = 1'b1;
            end
            muldiv_pkg::OP_MULTU: dec_mul = 1'b1;
            muldiv_pkg::OP_DIV: begin
                dec_div    = 1'b1;
                dec_signed = 1'b1;
            end
            muldiv_pkg::OP_DIVU:  dec_div = 1'b1;
            muldiv_pkg::OP_MADD: begin
                dec_mul    = 1'b1;
                dec_signed = 1'b1;
                dec_mode   = muldiv_pkg::WR_ADD;
            end
            muldiv_pkg::OP_MADDU: begin
                dec_mul  = 1'b1;
                dec_mode = muldiv_pkg::WR_ADD;
            end
            muldiv_pkg::OP_MSUB: begin
                dec_mul    = 1'b1;
                dec_signed = 1'b1;
                dec_mode   = muldiv_pkg::WR_SUB;
            end
            muldiv_pkg::OP_MSUBU: begin
                dec_mul  = 1'b1;
                dec_mode = muldiv_pkg::WR_SUB;
            end
            muldiv_pkg::OP_MTHI:  dec_mthi = 1'b1;
            muldiv_pkg::OP_MTLO:  dec_mtlo = 1'b1;
            default:              dec_mul  = 1'b0;  // unknown code is dropped
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q     <= SEQ_IDLE;
            mul_start_q <= 1'b0;
            div_start_q <= 1'b0;
            mov_hi_q    <= 1'b0;
            mov_lo_q    <= 1'b0;
        end else begin
            mul_start_q <= xfer && dec_mul;
            div_start_q <= xfer && dec_div;
            mov_hi_q    <= xfer && dec_mthi;
            mov_lo_q    <= xfer && dec_mtlo;
            case (state_q)
                SEQ_IDLE: begin
                    if (xfer && dec_mul) begin
                        state_q <= SEQ_WAIT_MUL;
                    end else if (xfer && dec_div) begin
                        state_q <= SEQ_WAIT_DIV;
                    end
                end
                SEQ_WAIT_MUL: if (mul_bus.done) state_q <= SEQ_IDLE;
                SEQ_WAIT_DIV: if (div_bus.done) state_q <= SEQ_IDLE;
                default:      state_q <= SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            opa_q  <= a_i;
            opb_q  <= b_i;
            sgn_q  <= dec_signed;
            mode_q <= dec_mode;  // load for divides
        end
    end

    assign mul_bus.start     = mul_start_q;
    assign mul_bus.a         = opa_q;
    assign mul_bus.b         = opb_q;
    assign mul_bus.is_signed = sgn_q;
    assign div_bus.start     = div_start_q;
    assign div_bus.a         = opa_q;
    assign div_bus.b         = opb_q;
    assign div_bus.is_signed = sgn_q;

    // divider result is already {rem, quo}, i.e. {hi, lo}
    assign wr_en_o   = (state_q == SEQ_WAIT_MUL && mul_bus.done)
                    || (state_q == SEQ_WAIT_DIV && div_bus.done);
    assign wr_mode_o = mode_q;
    assign wr_val_o  = (state_q == SEQ_WAIT_DIV) ? div_bus.result : mul_bus.result;
    assign mov_hi_o  = mov_hi_q;
    assign mov_lo_o  = mov_lo_q;
    assign mov_val_o = opa_q;

endmodule

// ==== design/muldiv_top.sv ====
`timescale 1ns/1ps

module muldiv_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            op_valid_i,
    output logic                            op_ready_o,
    input  muldiv_pkg::op_e                 op_code_i,
    input  logic [muldiv_pkg::XLEN-1:0]     a_i,
    input  logic [muldiv_pkg::XLEN-1:0]     b_i,
    input  logic                            flush_i,
    output logic [muldiv_pkg::XLEN-1:0]     hi_o,
    output logic [muldiv_pkg::XLEN-1:0]     lo_o
);

    logic                            wr_en;
    muldiv_pkg::hilo_wr_e            wr_mode;
    logic [2*muldiv_pkg::XLEN-1:0]   wr_val;
    logic                            mov_hi;
    logic                            mov_lo;
    logic [muldiv_pkg::XLEN-1:0]     mov_val;

    muldiv_unit_if mul_bus ();
    muldiv_unit_if div_bus ();

    muldiv_sequencer u_sequencer (
        .clk        (clk),
        .reset      (reset),
        .op_valid_i (op_valid_i),
        .op_ready_o (op_ready_o),
        .op_code_i  (op_code_i),
        .a_i        (a_i),
        .b_i        (b_i),
        .flush_i    (flush_i),
        .mul_bus    (mul_bus.ctrl),
        .div_bus    (div_bus.ctrl),
        .wr_en_o    (wr_en),
        .wr_mode_o  (wr_mode),
        .wr_val_o   (wr_val),
        .mov_hi_o   (mov_hi),
        .mov_lo_o   (mov_lo),
        .mov_val_o  (mov_val)
    );

    pipe_multiplier u_multiplier (
        .clk   (clk),
        .reset (reset),
        .bus   (mul_bus.unit)
    );

    radix2_divider u_divider (
        .clk   (clk),
        .reset (reset),
        .bus   (div_bus.unit)
    );

    hilo_regs u_hilo (
        .clk       (clk),
        .reset     (reset),
        .wr_en_i   (wr_en),
        .wr_mode_i (wr_mode),
        .wr_val_i  (wr_val),
        .mov_hi_i  (mov_hi),
        .mov_lo_i  (mov_lo),
        .mov_val_i (mov_val),
        .hi_o      (hi_o),
        .lo_o      (lo_o)
    );

endmodule

// ==== verif/muldiv_model.svh ====
`ifndef MULDIV_MODEL_SVH
`define MULDIV_MODEL_SVH

// 64-bit product of the operands, sign extended when signed
function automatic logic [63:0] full_product(input logic is_signed, input logic [31:0] opa,
                                             input logic [31:0] opb);
    logic [63:0] a_ext;
    logic [63:0] b_ext;
    a_ext = is_signed ? {{32{opa[31]}}, opa} : {32'b0, opa};
    b_ext = is_signed ? {{32{opb[31]}}, opb} : {32'b0, opb};
    return a_ext * b_ext;  // low 64 bits are exact
endfunction

// returns {remainder, quotient}
function automatic logic [63:0] divide_result(input logic is_signed, input logic [31:0] opa,
                                              input logic [31:0] opb);
    longint sa;
    longint sb;
    longint q;
    longint r;
    if (opb == 32'b0) begin
        return {opa, 32'hffff_ffff};  // divide by zero
    end
    if (is_signed) begin
        sa = $signed(opa);
        sb = $signed(opb);
        q  = sa / sb;  // truncates toward zero, -2^31 / -1 still fits
        r  = sa % sb;  // takes the dividend's sign
        return {r[31:0], q[31:0]};
    end
    return {opa % opb, opa / opb};
endfunction

// HI:LO after one operation
function automatic logic [63:0] next_hilo(input muldiv_pkg::op_e op, input logic [63:0] hilo,
                                          input logic [31:0] opa, input logic [31:0] opb);
    case (op)
        muldiv_pkg::OP_MULT:  return full_product(1'b1, opa, opb);
        muldiv_pkg::OP_MULTU: return full_product(1'b0, opa, opb);
        muldiv_pkg::OP_MADD:  return hilo + full_product(1'b1, opa, opb);
        muldiv_pkg::OP_MADDU: return hilo + full_product(1'b0, opa, opb);
        muldiv_pkg::OP_MSUB:  return hilo - full_product(1'b1, opa, opb);
        muldiv_pkg::OP_MSUBU: return hilo - full_product(1'b0, opa, opb);
        muldiv_pkg::OP_DIV:   return divide_result(1'b1, opa, opb);
        muldiv_pkg::OP_DIVU:  return divide_result(1'b0, opa, opb);
        muldiv_pkg::OP_MTHI:  return {opa, hilo[31:0]};
        muldiv_pkg::OP_MTLO:  return {hilo[63:32], opa};
        default:              return hilo;
    endcase
endfunction

`endif

// ==== verif/muldiv_tb.sv ====
`timescale 1ns/1ps

module muldiv_tb;

    `include "muldiv_model.svh"

    localparam int N_RAND_MUL   = 4;
    localparam int N_MAC_ROUNDS = 3;
    localparam int N_RAND_DIV   = 4;  // covers all four sign pairs
    localparam int N_OPS        = 2 + (6 + 2 * N_RAND_MUL) + (2 + 4 * N_MAC_ROUNDS)
                                + (2 * N_RAND_DIV + 4) + 4;
    localparam int CYCLE_LIMIT  = 40 * N_OPS + 100;

    logic            clk;
    logic            reset;
    logic            op_valid;
    logic            op_ready;
    muldiv_pkg::op_e op_code;
    logic [31:0]     a;
    logic [31:0]     b;
    logic            flush;
    logic [31:0]     hi;
    logic [31:0]     lo;

    int          cycle_cnt  = 0;
    int          checks     = 0;
    int          errors     = 0;
    int          test_start = 0;  // error count when the current test began
    logic [63:0] model_hilo = '0;

    muldiv_top UUT (
        .clk        (clk),
        .reset      (reset),
        .op_valid_i (op_valid),
        .op_ready_o (op_ready),
        .op_code_i  (op_code),
        .a_i        (a),
        .b_i        (b),
        .flush_i    (flush),
        .hi_o       (hi),
        .lo_o       (lo)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    always @(negedge clk) begin
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $finish;
        end
    end

    // cycles of op_ready low after a transfer
    function automatic int busy_cycles(input muldiv_pkg::op_e op);
        case (op)
            muldiv_pkg::OP_MTHI, muldiv_pkg::OP_MTLO: return 0;
            muldiv_pkg::OP_DIV, muldiv_pkg::OP_DIVU:  return muldiv_pkg::DIV_STEPS + 3;
            default:                                  return muldiv_pkg::MULT_STAGES + 2;
        endcase
    endfunction

    task automatic compare_value(input string what, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic offer_op(input muldiv_pkg::op_e op, input logic [31:0] opa,
                            input logic [31:0] opb, output int xfer_cnt);
        op_valid = 1'b1;
        op_code  = op;
        a        = opa;
        b        = opb;
        while (!op_ready) @(negedge clk);  // producer stalls
        @(negedge clk);
        xfer_cnt = cycle_cnt;
    endtask

    task automatic wait_ready(input int xfer_cnt, output int busy);
        while (!op_ready) @(negedge clk);
        busy = cycle_cnt - xfer_cnt;
    endtask

    task automatic run_op(input muldiv_pkg::op_e op, input logic [31:0] opa,
                          input logic [31:0] opb);
        logic [63:0] exp_hilo;
        int          xfer_cnt;
        int          busy;
        exp_hilo = next_hilo(op, model_hilo, opa, opb);
        offer_op(op, opa, opb, xfer_cnt);
        op_valid = 1'b0;
        wait_ready(xfer_cnt, busy);
        compare_value($sformatf("%s busy cycles", op.name()), busy, busy_cycles(op));
        if (busy_cycles(op) == 0) begin
            @(negedge clk);  // move lands one edge later
            compare_value($sformatf("%s op_ready", op.name()), op_ready, 1);
        end
        compare_value($sformatf("%s hi", op.name()), hi, exp_hilo[63:32]);
        compare_value($sformatf("%s lo", op.name()), lo, exp_hilo[31:0]);
        model_hilo = exp_hilo;
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s: %s", num, name, (errors == test_start) ? "ok" : "mismatch");
        test_start = errors;
    endtask

    initial begin
        logic [31:0] ra;
        logic [31:0] rb;
        logic [63:0] exp_hilo;
        int          xfer_cnt;
        int          busy;
        int          rnd_seed;
        rnd_seed = $urandom(23);
        clk      = 1'b0;
        reset    = 1'b1;
        op_valid = 1'b0;
        op_code  = muldiv_pkg::OP_MULT;
        a        = '0;
        b        = '0;
        flush    = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        compare_value("hi after reset", hi, 0);
        compare_value("lo after reset", lo, 0);
        compare_value("op_ready after reset", op_ready, 1);
        run_op(muldiv_pkg::OP_MTHI, 32'h1234_5678, 32'h0);
        run_op(muldiv_pkg::OP_MTLO, 32'h9abc_def0, 32'h0);
        report_test(1, "reset and moves");

        run_op(muldiv_pkg::OP_MULT,  32'h8000_0000, 32'h8000_0000);
        run_op(muldiv_pkg::OP_MULTU, 32'h8000_0000, 32'h8000_0000);
        run_op(muldiv_pkg::OP_MULT,  32'hffff_ffff, 32'hffff_ffff);
        run_op(muldiv_pkg::OP_MULTU, 32'hffff_ffff, 32'hffff_ffff);
        run_op(muldiv_pkg::OP_MULT,  32'h8000_0000, 32'hffff_ffff);
        run_op(muldiv_pkg::OP_MULTU, 32'h8000_0000, 32'hffff_ffff);
        for (int i = 0; i < N_RAND_MUL; i++) begin
            ra = $urandom();
            rb = $urandom();
            run_op(muldiv_pkg::OP_MULT, ra, rb);
            run_op(muldiv_pkg::OP_MULTU, ra, rb);
        end
        report_test(2, "multiply");

        run_op(muldiv_pkg::OP_MTHI, $urandom(), 32'h0);  // preload
        run_op(muldiv_pkg::OP_MTLO, $urandom(), 32'h0);
        for (int i = 0; i < N_MAC_ROUNDS; i++) begin
            run_op(muldiv_pkg::OP_MADD,  $urandom(), $urandom());
            run_op(muldiv_pkg::OP_MADDU, $urandom(), $urandom());
            run_op(muldiv_pkg::OP_MSUB,  $urandom(), $urandom());
            run_op(muldiv_pkg::OP_MSUBU, $urandom(), $urandom());
        end
        report_test(3, "multiply accumulate");

        for (int i = 0; i < N_RAND_DIV; i++) begin
            ra = $urandom() & 32'h7fff_ffff;
            rb = ($urandom() & 32'h0000_ffff) | 32'h1;
            if (i % 2 == 1) ra = -ra;
            if ((i / 2) % 2 == 1) rb = -rb;
            run_op(muldiv_pkg::OP_DIV, ra, rb);
            run_op(muldiv_pkg::OP_DIVU, ra, rb);
        end
        run_op(muldiv_pkg::OP_DIV, 32'hffff_fff9, 32'h2);  // -7 / 2
        compare_value("div -7/2 hi:lo", {hi, lo}, 64'hffff_ffff_ffff_fffd);
        run_op(muldiv_pkg::OP_DIV, 32'h8000_0000, 32'hffff_ffff);
        compare_value("div overflow hi:lo", {hi, lo}, 64'h0000_0000_8000_0000);
        run_op(muldiv_pkg::OP_DIV, 32'hffff_fff9, 32'h0);
        compare_value("div by zero hi:lo", {hi, lo}, 64'hffff_fff9_ffff_ffff);
        run_op(muldiv_pkg::OP_DIVU, 32'h1234_5678, 32'h0);
        compare_value("divu by zero hi:lo", {hi, lo}, 64'h1234_5678_ffff_ffff);
        report_test(4, "divide");

        // offers under flush must be dropped
        flush    = 1'b1;
        op_valid = 1'b1;
        op_code  = muldiv_pkg::OP_MTHI;
        a        = 32'hdead_beef;
        repeat (3) begin
            @(negedge clk);
            compare_value("op_ready under flush", op_ready, 1);
        end
        compare_value("hi:lo after flushed move", {hi, lo}, model_hilo);
        op_code = muldiv_pkg::OP_MULT;
        b       = 32'h0000_0003;
        repeat (2) begin
            @(negedge clk);
            compare_value("op_ready under flush", op_ready, 1);
        end
        op_valid = 1'b0;
        flush    = 1'b0;
        @(negedge clk);
        compare_value("op_ready after flush", op_ready, 1);
        compare_value("hi:lo after flushed multiply", {hi, lo}, model_hilo);

        // next offer held while the divider is busy
        exp_hilo = next_hilo(muldiv_pkg::OP_DIV, model_hilo, 32'h8765_4321, 32'h0000_1234);
        offer_op(muldiv_pkg::OP_DIV, 32'h8765_4321, 32'h0000_1234, xfer_cnt);
        op_code = muldiv_pkg::OP_MADD;
        a       = 32'h0001_0001;
        b       = 32'hffff_fff0;
        wait_ready(xfer_cnt, busy);
        compare_value("held offer div busy cycles", busy, busy_cycles(muldiv_pkg::OP_DIV));
        compare_value("held offer div hi:lo", {hi, lo}, exp_hilo);
        model_hilo = exp_hilo;
        exp_hilo   = next_hilo(muldiv_pkg::OP_MADD, model_hilo, a, b);
        offer_op(muldiv_pkg::OP_MADD, a, b, xfer_cnt);
        op_valid = 1'b0;
        compare_value("op_ready after held transfer", op_ready, 0);
        wait_ready(xfer_cnt, busy);
        compare_value("held madd busy cycles", busy, busy_cycles(muldiv_pkg::OP_MADD));
        compare_value("held madd hi:lo", {hi, lo}, exp_hilo);
        model_hilo = exp_hilo;
        report_test(5, "flush and back-pressure");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+verif
design/muldiv_pkg.sv
design/muldiv_unit_if.sv
design/hilo_regs.sv
design/pipe_multiplier.sv
design/radix2_divider.sv
design/muldiv_sequencer.sv
design/muldiv_top.sv
verif/muldiv_tb.sv
